// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f sources.f \
		--top-module tagAllocTb -Mdir obj_dir
	@out="$$(./obj_dir/VtagAllocTb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^No errors$$"

clean:
	rm -rf obj_dir

// ==== sim/tagAllocChecker.sv ====
`timescale 1ns/1ps
`include "tagAlloc_params.svh"

module tagAllocChecker (
    input logic               rst,
    input logic               reset,
    input int                 testId,
    input logic               issueValid,
    input tagAllocPkg::rsUnit issueUnit,
    input logic               cdbValid,
    input tagAllocPkg::rsTag  cdbTag,
    input logic               issueGranted,
    input logic               issueStall,
    input tagAllocPkg::rsTag  issueTag
);

    logic [`RS_SIZE-1:0] aluBusy;
    logic [`RS_SIZE-1:0] lsBusy;
    logic [`RS_SIZE-1:0] aluNext;      // Model state once the applied inputs take effect
    logic [`RS_SIZE-1:0] lsNext;
    int checkCount = 0;
    int errCount   = 0;
    int testChecks = 0;
    int testErrs   = 0;
    int testsDone  = 0;
    int shownId    = 0;

    function automatic string testName(input int id);
        case (id)
            1: return "reset";
            2: return "fill";
            3: return "release";
            4: return "sameCycle";
            5: return "crossFull";
            6: return "randomMix";
            default: return "idle";
        endcase
    endfunction

    // Scans from entry 0 upward for the first entry that is not busy
    function automatic logic [`SLOT_W-1:0] lowestFree(input logic [`RS_SIZE-1:0] map);
        for (int b = 0; b < `RS_SIZE; b++) begin
            if (!map[b]) begin
                return b[`SLOT_W-1:0];
            end
        end
        return `NO_FREE_SLOT;
    endfunction

    task automatic compareVal(input string what, input int expected, input int actual);
        checkCount++;
        testChecks++;
        if (expected != actual) begin
            errCount++;
            testErrs++;
            $display("ERR %s %s: expected 0x%0h, actual 0x%0h",
                     testName(testId), what, expected, actual);
        end
    endtask

    always_comb begin
        aluNext = aluBusy;
        lsNext  = lsBusy;
        if (issueValid && issueUnit == tagAllocPkg::ALU && !(&aluBusy)) begin
            aluNext[lowestFree(aluBusy)] = 1'b1;
        end
        if (issueValid && issueUnit == tagAllocPkg::LS && !(&lsBusy)) begin
            lsNext[lowestFree(lsBusy)] = 1'b1;
        end
        if (cdbValid && cdbTag.unit == tagAllocPkg::ALU) begin
            aluNext[cdbTag.slot] = 1'b0;
        end
        if (cdbValid && cdbTag.unit == tagAllocPkg::LS) begin
            lsNext[cdbTag.slot] = 1'b0;
        end
    end

    always @(posedge rst) begin
        logic [`RS_SIZE-1:0] sel;
        logic                expFull;
        tagAllocPkg::rsTag   expTag;
        if (reset) begin
            aluBusy <= '0;
            lsBusy  <= '0;
        end else begin
            sel     = (issueUnit == tagAllocPkg::LS) ? lsBusy : aluBusy;
            expFull = &sel;
            compareVal("grant", int'(issueValid && !expFull), int'(issueGranted));
            compareVal("stall", int'(issueValid && expFull), int'(issueStall));
            if (issueValid && !expFull) begin
                expTag.unit = issueUnit;
                expTag.slot = lowestFree(sel);
                compareVal("tag", int'(expTag), int'(issueTag));
            end
            aluBusy <= aluNext;
            lsBusy  <= lsNext;
        end
    end

    always @(testId) begin
        if (shownId != 0) begin
            $display("Test %s finished: %0d checks, %0d errors",
                     testName(shownId), testChecks, testErrs);
            testsDone++;
        end
        testChecks = 0;
        testErrs   = 0;
        shownId    = testId;
    end

endmodule

// ==== sim/tagAllocTb.sv ====
`timescale 1ns/1ps
`include "tagAlloc_params.svh"

module tagAllocTb;

    localparam int WAIT_LIMIT = 20;    // Cycles allowed for any single wait

    logic               rst;
    logic               reset;
    logic               issueValid;
    tagAllocPkg::rsUnit issueUnit;
    logic               cdbValid;
    tagAllocPkg::rsTag  cdbTag;
    logic               issueGranted;
    logic               issueStall;
    tagAllocPkg::rsTag  issueTag;
    int                 testId;
    int                 seed;
    int                 timeouts;

    initial begin
        rst = 1'b0;
        forever #5 rst = ~rst;
    end

    tagAllocTop DUT (
        .rst          (rst),
        .reset        (reset),
        .issueValid   (issueValid),
        .issueUnit    (issueUnit),
        .cdbValid     (cdbValid),
        .cdbTag       (cdbTag),
        .issueGranted (issueGranted),
        .issueStall   (issueStall),
        .issueTag     (issueTag)
    );

    tagAllocChecker chk (
        .rst          (rst),
        .reset        (reset),
        .testId       (testId),
        .issueValid   (issueValid),
        .issueUnit    (issueUnit),
        .cdbValid     (cdbValid),
        .cdbTag       (cdbTag),
        .issueGranted (issueGranted),
        .issueStall   (issueStall),
        .issueTag     (issueTag)
    );

    // Random busy entry of a bitmap, or -1 when nothing is busy
    function automatic int pickBusy(input logic [`RS_SIZE-1:0] map);
        int n;
        int k;
        n = $countones(map);
        if (n == 0) begin
            return -1;
        end
        k = ($random(seed) & 32'h7fffffff) % n;
        for (int b = 0; b < `RS_SIZE; b++) begin
            if (map[b]) begin
                if (k == 0) begin
                    return b;
                end
                k--;
            end
        end
        return -1;
    endfunction

    task automatic driveCycle(input logic iv, input tagAllocPkg::rsUnit unit,
                              input logic cv, input tagAllocPkg::rsTag tag);
        issueValid <= iv;
        issueUnit  <= unit;
        cdbValid   <= cv;
        cdbTag     <= tag;
        @(posedge rst);
    endtask

    task automatic idleCycle();
        driveCycle(1'b0, tagAllocPkg::ALU, 1'b0, '0);
    endtask

    task automatic releaseSlot(input tagAllocPkg::rsUnit unit, input int slot);
        driveCycle(1'b0, unit, 1'b1, {unit, slot[`SLOT_W-1:0]});
    endtask

    task automatic issueUntilGranted(input tagAllocPkg::rsUnit unit);
        int waited;
        waited = 0;
        issueValid <= 1'b1;
        issueUnit  <= unit;
        cdbValid   <= 1'b0;
        do begin
            @(posedge rst);
            waited++;
        end while (!issueGranted && waited < WAIT_LIMIT);
        if (!issueGranted) begin
            $display("Timeout: issue to unit %s was never granted", unit.name());
            timeouts++;
        end
    endtask

    task automatic holdUntilStall(input tagAllocPkg::rsUnit unit);
        int waited;
        waited = 0;
        issueValid <= 1'b1;
        issueUnit  <= unit;
        cdbValid   <= 1'b0;
        do begin
            @(posedge rst);
            waited++;
        end while (!issueStall && waited < WAIT_LIMIT);
        if (!issueStall) begin
            $display("Timeout: issue to full unit %s never stalled", unit.name());
            timeouts++;
        end else begin
            @(posedge rst);                 // Keep the stalled request up one more cycle
        end
    endtask

    task automatic randomCycle();
        int                 r;
        int                 slot;
        tagAllocPkg::rsUnit relUnit;
        r       = $random(seed);
        relUnit = tagAllocPkg::rsUnit'(r[2]);
        slot    = pickBusy(relUnit == tagAllocPkg::LS ? chk.lsNext : chk.aluNext);
        driveCycle(r[0] | r[1], tagAllocPkg::rsUnit'(r[3]),
                   (r[4] | r[5]) && slot >= 0, {relUnit, slot[`SLOT_W-1:0]});
    endtask

    initial begin
        tagAllocPkg::rsUnit first;
        int                 slot;
        int                 other;
        seed       = 32'h90012c53;
        timeouts   = 0;
        testId     = 0;
        reset      = 1'b1;
        issueValid = 1'b0;
        issueUnit  = tagAllocPkg::ALU;
        cdbValid   = 1'b0;
        cdbTag     = '0;
        repeat (4) @(posedge rst);
        reset <= 1'b0;

        testId <= 1;
        slot = $random(seed);
        first = tagAllocPkg::rsUnit'(slot[0]);    // Either bank may go first
        issueUntilGranted(first);
        issueUntilGranted(tagAllocPkg::rsUnit'(~first));
        releaseSlot(tagAllocPkg::ALU, 0);
        releaseSlot(tagAllocPkg::LS, 0);
        idleCycle();

        testId <= 2;
        repeat (`RS_SIZE) issueUntilGranted(tagAllocPkg::ALU);
        holdUntilStall(tagAllocPkg::ALU);
        idleCycle();

        testId <= 3;
        repeat (3) begin
            slot = pickBusy(chk.aluNext);
            releaseSlot(tagAllocPkg::ALU, slot);
            issueUntilGranted(tagAllocPkg::ALU);
        end
        idleCycle();

        testId <= 4;
        slot = `RS_SIZE - 1;                    // Every other busy entry lies below it
        releaseSlot(tagAllocPkg::ALU, slot);
        other = pickBusy(chk.aluNext);          // Freed together with an issue below
        driveCycle(1'b1, tagAllocPkg::ALU, 1'b1, {tagAllocPkg::ALU, other[`SLOT_W-1:0]});
        issueUntilGranted(tagAllocPkg::ALU);
        idleCycle();

        testId <= 5;
        repeat (`RS_SIZE) issueUntilGranted(tagAllocPkg::LS);
        holdUntilStall(tagAllocPkg::ALU);
        slot = pickBusy(chk.aluNext);
        releaseSlot(tagAllocPkg::ALU, slot);
        issueUntilGranted(tagAllocPkg::ALU);
        holdUntilStall(tagAllocPkg::LS);
        idleCycle();

        testId <= 6;
        repeat (400) randomCycle();
        idleCycle();

        testId <= 7;
        repeat (2) idleCycle();
        $display("Summary: %0d tests, %0d checks, %0d errors, %0d timeouts",
                 chk.testsDone, chk.checkCount, chk.errCount, timeouts);
        if (chk.errCount == 0 && timeouts == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+src
src/tagAllocPkg.sv
src/rsBankIf.sv
src/freeSlotTable.sv
src/rsBank.sv
src/issueSteer.sv
src/tagAllocTop.sv
sim/tagAllocChecker.sv
sim/tagAllocTb.sv

// ==== src/freeSlotTable.sv ====
`timescale 1ns/1ps
`include "tagAlloc_params.svh"

module freeSlotTable (
    input  logic [`RS_SIZE-1:0] freeMap,    // One bit per entry, set when free
    output logic [`SLOT_W-1:0]  slot
);

    typedef logic [`SLOT_W-1:0] slotTableT [`TABLE_DEPTH];

    // Entry i holds the lowest set bit of i, so entry 0 means nothing is free
    function automatic slotTableT buildTable();
        slotTableT t;
        for (int i = 0; i < `TABLE_DEPTH; i++) begin
            t[i] = `NO_FREE_SLOT;
            for (int b = `RS_SIZE - 1; b >= 0; b--) begin
                if (i[b]) begin
                    t[i] = b[`SLOT_W-1:0];  // Lower bits overwrite higher ones
                end
            end
        end
        return t;
    endfunction

    localparam slotTableT SLOT_TABLE = buildTable();

    assign slot = SLOT_TABLE[freeMap];  // Pure lookup, no state

endmodule

// ==== src/issueSteer.sv ====
`timescale 1ns/1ps
`include "tagAlloc_params.svh"

module issueSteer (
    input  logic               issueValid,
    input  tagAllocPkg::rsUnit issueUnit,
    input  logic               cdbValid,
    input  tagAllocPkg::rsTag  cdbTag,
    output logic               issueGranted,
    output logic               issueStall,
    output tagAllocPkg::rsTag  issueTag,
    rsBankIf.steer             alu,
    rsBankIf.steer             ls
);

    logic               toAlu;
    logic               toLs;
    logic               selFull;
    logic [`SLOT_W-1:0] selSlot;
    logic               cdbToAlu;
    logic               cdbToLs;

    assign toAlu = (issueUnit == tagAllocPkg::ALU);
    assign toLs  = (issueUnit == tagAllocPkg::LS);

    // Only the bank of the issuing class is looked at
    assign selFull = toLs ? ls.full : alu.full;
    assign selSlot = toLs ? ls.freeSlot : alu.freeSlot;

    assign issueGranted  = issueValid && !selFull;
    assign issueStall    = issueValid && selFull;    // Nothing is taken while stalled
    assign issueTag.unit = issueUnit;
    assign issueTag.slot = selSlot;

    assign alu.alloc = issueGranted && toAlu;
    assign ls.alloc  = issueGranted && toLs;

    // The unit field of the broadcast tag names the owning bank
    assign cdbToAlu = cdbValid && (cdbTag.unit == tagAllocPkg::ALU);
    assign cdbToLs  = cdbValid && (cdbTag.unit == tagAllocPkg::LS);

    assign alu.releaseEn   = cdbToAlu;
    assign alu.releaseSlot = cdbTag.slot;
    assign ls.releaseEn    = cdbToLs;
    assign ls.releaseSlot  = cdbTag.slot;

endmodule

// ==== src/rsBank.sv ====
`timescale 1ns/1ps
`include "tagAlloc_params.svh"

module rsBank (
    input logic    rst,
    input logic    reset,
    rsBankIf.bank  port
);

    logic [`RS_SIZE-1:0] busy;
    logic [`RS_SIZE-1:0] freeMap;
    logic [`RS_SIZE-1:0] setMask;
    logic [`RS_SIZE-1:0] clrMask;
    logic [`SLOT_W-1:0]  tableSlot;

    assign freeMap = ~busy;

    freeSlotTable slotTable (
        .freeMap (freeMap),
        .slot    (tableSlot)
    );

    assign port.freeSlot = tableSlot;
    assign port.full     = (tableSlot == `NO_FREE_SLOT);

    // Allocation picks from the bitmap as it stands before this cycle's release
    assign setMask = (port.alloc && !port.full) ? (`RS_SIZE'(1) << tableSlot) : '0;
    assign clrMask = port.releaseEn ? (`RS_SIZE'(1) << port.releaseSlot) : '0;

    always_ff @(posedge rst) begin
        if (reset) begin
            busy <= '0;                             // All entries free
        end else begin
            busy <= (busy & ~clrMask) | setMask;
        end
    end

    // The steering block must gate its strobe with this bank's full flag
    allocNotFull: assert property (
        @(posedge rst) disable iff (reset)
        port.alloc |-> !port.full
    ) else $error("rsBank: alloc while bank is full");

    // Broadcasts on the data bus may only complete entries that are in flight
    releaseBusy: assert property (
        @(posedge rst) disable iff (reset)
        port.releaseEn |-> (port.releaseSlot < `RS_SIZE) && busy[port.releaseSlot]
    ) else $error("rsBank: release of slot %0d which is not busy", port.releaseSlot);

endmodule

// ==== src/rsBankIf.sv ====
`timescale 1ns/1ps
`include "tagAlloc_params.svh"

interface rsBankIf;

    logic [`SLOT_W-1:0] freeSlot;       // Lowest free entry, NO_FREE_SLOT when full
    logic               full;
    logic               alloc;          // Claims freeSlot at the next rising edge
    logic               releaseEn;      // Frees releaseSlot at the next rising edge
    logic [`SLOT_W-1:0] releaseSlot;

    modport bank (
        output freeSlot,
        output full,
        input  alloc,
        input  releaseEn,
        input  releaseSlot
    );

    modport steer (
        input  freeSlot,
        input  full,
        output alloc,
        output releaseEn,
        output releaseSlot
    );

endinterface

// ==== src/tagAllocPkg.sv ====
`include "tagAlloc_params.svh"

package tagAllocPkg;

    // Issuing class and owning bank share one encoding
    typedef enum logic {
        ALU = 1'b0,
        LS  = 1'b1
    } rsUnit;

    // Global tag carried on issue and on the common data bus
    typedef struct packed {
        rsUnit              unit;   // Bank that owns the entry
        logic [`SLOT_W-1:0] slot;   // Entry inside that bank
    } rsTag;

endpackage

// ==== src/tagAllocTop.sv ====
`timescale 1ns/1ps

module tagAllocTop (
    input  logic               rst,            // Clock
    input  logic               reset,
    input  logic               issueValid,
    input  tagAllocPkg::rsUnit issueUnit,
    input  logic               cdbValid,
    input  tagAllocPkg::rsTag  cdbTag,
    output logic               issueGranted,
    output logic               issueStall,
    output tagAllocPkg::rsTag  issueTag
);

    rsBankIf aluIf ();
    rsBankIf lsIf ();

    rsBank aluBank (
        .rst   (rst),
        .reset (reset),
        .port  (aluIf.bank)
    );

    rsBank lsBank (
        .rst   (rst),
        .reset (reset),
        .port  (lsIf.bank)
    );

    // Issue and completion both go through the steering block
    issueSteer steer (
        .issueValid   (issueValid),
        .issueUnit    (issueUnit),
        .cdbValid     (cdbValid),
        .cdbTag       (cdbTag),
        .issueGranted (issueGranted),
        .issueStall   (issueStall),
        .issueTag     (issueTag),
        .alu          (aluIf.steer),
        .ls           (lsIf.steer)
    );

endmodule

// ==== src/tagAlloc_params.svh ====
`ifndef TAGALLOC_PARAMS_SVH
`define TAGALLOC_PARAMS_SVH

// Sizing of the two reservation-station banks

`define RS_SIZE 6          // Entries per bank

`define SLOT_W 3           // Bits needed to name one entry

`define TABLE_DEPTH 64     // One lookup entry per possible free bitmap

`define NO_FREE_SLOT 3'b111 // Slot code returned by a full bank

`endif
